// ==== border_blanker.f ====
+incdir+dv
rtl/video_timing_pkg.sv
rtl/border_regs_pkg.sv
rtl/border_apb_regs.sv
rtl/hblank_trimmer.sv
rtl/vblank_trimmer.sv
rtl/mode_monitor.sv
rtl/border_blanker.sv
dv/border_blanker_tb.sv

// ==== Bender.yml ====
package:
  name: border_blanker

sources:
  - rtl/video_timing_pkg.sv
  - rtl/border_regs_pkg.sv
  - rtl/border_apb_regs.sv
  - rtl/hblank_trimmer.sv
  - rtl/vblank_trimmer.sv
  - rtl/mode_monitor.sv
  - rtl/border_blanker.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/border_blanker_tb.sv

// ==== dv/tb_video_tasks.svh ====
// included inside border_blanker_tb, drives its video and apb_req variables directly
`ifndef TB_VIDEO_TASKS_SVH
`define TB_VIDEO_TASKS_SVH

// setup cycle, access cycle, then bus idle again
task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	@(posedge clk_sys);
	#5;
	apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
	@(posedge clk_sys);
	#5;
	apb_req.penable = 1'b1;
	@(negedge clk_sys); // response sampled mid access cycle
	rdata = apb_rsp.prdata;
	err   = apb_rsp.pslverr;
	assert (apb_rsp.pready) else begin
		err_cnt++;
		$display("access at %0t did not complete in two cycles", $time);
	end
	@(posedge clk_sys);
	#5;
	apb_req = '0;
endtask

// one frame, vblank rises with the first line, two vsync lines
task automatic drive_frame(input int act_w, input int vb_n, input int act_n);
	int line_len;
	int g;
	int c;
	line_len = hsync_len + back_porch + act_w + front_porch;
	for (g = 0; g < vb_n + act_n; g++) begin
		for (c = 0; c < line_len; c++) begin
			@(posedge clk_sys);
			#5;
			if (c == 0 && g == 0) begin
				frame_cnt++;
				for (int i = 0; i < 256; i++) de_cnt[frame_cnt % 2][i] = 0;
			end
			cur_line     = g;
			video.hs_n   = (c >= hsync_len);
			video.hblank = (c < hsync_len + back_porch) || (c >= hsync_len + back_porch + act_w);
			video.vblank = (g < vb_n);
			video.vs_n   = (g >= 2);
		end
	end
endtask

`endif

// ==== dv/border_blanker_tb.sv ====
// fixed geometry of 6 blank and 20 active lines, trims stay small so no counter wraps
`timescale 1ns/1ps

module border_blanker_tb;
	import border_regs_pkg::*;
	import video_timing_pkg::*;

	localparam int vb_lines = 6;
	localparam int act_lines = 20;
	localparam int width_a = 64;
	localparam int width_b = 80;
	localparam int hsync_len = 8;
	localparam int back_porch = 24;
	localparam int front_porch = 24;
	localparam int mid_line = vb_lines + act_lines / 2;
	localparam int total_frames = 24; // 1 + 2 + 3 + 4 + 6 + 8 over the six tests
	localparam real frame_ns = 100.0 * (vb_lines + act_lines) *
		(hsync_len + back_porch + width_b + front_porch);

	logic        clk_sys = 1'b0;
	logic        reset = 1'b1;
	video_in_t   video;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        de;
	logic [31:0] rdata;
	logic        err;
	int          frame_cnt = 0;
	int          cur_line = 0;
	int          gen_width = width_a;
	int          de_cnt [2][256];  // de cycles per line, two frames deep
	int          err_cnt = 0;
	int          err_mark = 0;
	int          pass_tests = 0;
	int          fail_tests = 0;

	`include "tb_video_tasks.svh"

	always #50 clk_sys = ~clk_sys;

	border_blanker border_blanker_i (.clk_sys(clk_sys), .reset(reset), .video(video),
		.apb_req(apb_req), .apb_rsp(apb_rsp), .de(de));

	always drive_frame(gen_width, vb_lines, act_lines);

	always @(negedge clk_sys) if (de === 1'b1) de_cnt[frame_cnt % 2][cur_line] += 1;

	assert property (@(posedge clk_sys) disable iff (reset) apb_rsp.pready) else begin
		err_cnt++;
		$display("[ERROR] %0t apb_rsp.pready expected 1 got 0", $time);
	end
	assert property (@(posedge clk_sys) disable iff (reset)
		apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable)) else begin
		err_cnt++;
		$display("pslverr raised outside an access cycle at %0t", $time);
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == err_mark) begin
			pass_tests++;
			$display("test %s passed", name);
		end else begin
			fail_tests++;
			$display("test %s failed with %0d errors", name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		while (frame_cnt < target) @(posedge clk_sys);
	endtask

	task automatic write_reg(input logic [7:0] addr, input int value);
		apb_access(1'b1, addr, value, rdata, err);
		check_value("pslverr", err, 0);
	endtask

	task automatic read_reg(input logic [7:0] addr, input string name, input int exp);
		apb_access(1'b0, addr, '0, rdata, err);
		check_value("pslverr", err, 0);
		check_value(name, rdata, exp);
	endtask

	// lines of the last finished frame holding at least half a line of de
	task automatic count_de_lines(output int n, output int last);
		n = 0;
		last = -1;
		for (int g = 0; g < vb_lines + act_lines; g++) begin
			if (de_cnt[(frame_cnt + 1) % 2][g] >= gen_width / 2) begin
				n++;
				last = g;
			end
		end
	endtask

	task automatic read_mode_count(output int cnt);
		repeat (4) @(posedge clk_sys); // frame_done plus the count update
		apb_access(1'b0, reg_mode, '0, rdata, err);
		check_value("reg_mode.res", rdata[1:0], 0);
		cnt = rdata[14:8];
	endtask

	initial begin
		int seed;
		int trim_l;
		int h0;
		int n;
		int last;
		int c0;
		int c;
		seed = $urandom(6);
		video = '{hs_n: 1'b1, vs_n: 1'b1, hblank: 1'b1, vblank: 1'b1, res: 2'd0};
		apb_req = '0;
		repeat (5) @(posedge clk_sys);
		#5;
		reset = 1'b0;

		check_value("de", de, 0);
		read_reg(reg_trim_left, "trim_left", 0);
		read_reg(reg_trim_right, "trim_right", 0);
		read_reg(reg_trim_top, "trim_top", 0);
		read_reg(reg_trim_bottom, "trim_bottom", 0);
		trim_l = $urandom_range(31, 0);
		write_reg(reg_trim_left, trim_l);
		read_reg(reg_trim_left, "trim_left", trim_l);
		trim_l = $urandom_range(31, 0);
		write_reg(reg_trim_right, trim_l);
		read_reg(reg_trim_right, "trim_right", trim_l);
		trim_l = $urandom_range(3, 0);
		write_reg(reg_trim_top, trim_l);
		read_reg(reg_trim_top, "trim_top", trim_l);
		trim_l = $urandom_range(15, 0);
		write_reg(reg_trim_bottom, trim_l);
		read_reg(reg_trim_bottom, "trim_bottom", trim_l);
		write_reg(reg_trim_left, 0);
		write_reg(reg_trim_right, 0);
		write_reg(reg_trim_top, 0);
		write_reg(reg_trim_bottom, 0);
		finish_test("reset_and_access");

		wait_frames(2);
		apb_access(1'b0, 8'h20, '0, rdata, err);
		check_value("pslverr", err, 1);
		apb_access(1'b1, reg_hsize, 32'h123, rdata, err);
		check_value("pslverr", err, 1);
		read_reg(reg_hsize, "hsize", width_a);
		read_reg(reg_trim_left, "trim_left", 0);
		finish_test("bus_errors");

		wait_frames(3);
		read_reg(reg_hsize, "hsize", width_a);
		read_reg(reg_vsize, "vsize", act_lines);
		finish_test("measurement");

		wait_frames(2);
		h0 = de_cnt[(frame_cnt + 1) % 2][mid_line];
		check_value("de cycles", h0, width_a);
		trim_l = 4 * $urandom_range(3, 1);
		write_reg(reg_trim_left, trim_l);
		wait_frames(2);
		check_value("de cycles", de_cnt[(frame_cnt + 1) % 2][mid_line], width_a - trim_l);
		write_reg(reg_trim_left, 0);
		finish_test("horizontal_trim");

		// top opens at the last vblank line, the forced margin darkens the last line
		wait_frames(2);
		count_de_lines(n, last);
		check_value("de lines", n, act_lines);
		check_value("last de line", last, vb_lines + act_lines - 2);
		write_reg(reg_trim_bottom, mid_line);
		wait_frames(2);
		count_de_lines(n, last);
		check_value("last de line", last, mid_line - 1);
		check_value("de lines", n, mid_line - vb_lines + 1);
		write_reg(reg_trim_bottom, 32'h805); // from_end, back five lines
		wait_frames(2);
		count_de_lines(n, last);
		check_value("last de line", last, vb_lines + act_lines - 2 - 5);
		check_value("de lines", n, act_lines - 5);
		write_reg(reg_trim_bottom, 0);
		finish_test("bottom_trim");

		wait_frames(1);
		read_mode_count(c0);
		repeat (3) begin
			wait_frames(1);
			read_mode_count(c);
			check_value("change_count", c, c0);
		end
		gen_width = width_b;
		wait_frames(2);
		read_mode_count(c);
		check_value("change_count step", (c - c0) & 7'h7f, 1);
		c0 = c;
		repeat (2) begin
			wait_frames(1);
			read_mode_count(c);
			check_value("change_count", c, c0);
		end
		finish_test("mode_change");

		$display("tests passed %0d failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(1.5 * total_frames * frame_ns);
		$display("watchdog expired before the tests finished");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== rtl/border_blanker.sv ====
// single clock design, video and APB both on clk_sys, de is registered
`timescale 1ns/1ps

module border_blanker (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  video_timing_pkg::video_in_t video,
	input  border_regs_pkg::apb_req_t   apb_req,
	output border_regs_pkg::apb_rsp_t   apb_rsp,
	output logic                        de
);
	import video_timing_pkg::*;

	trim_t      trims;
	logic       line_hbl;
	coord_t     line_width;
	logic       width_valid;
	coord_t     line_idx;
	coord_t     frame_height;
	logic       frame_done;
	coord_t     meas_width;
	logic [6:0] change_count;

	border_apb_regs border_apb_regs_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.trims        (trims),
		.meas_width   (meas_width),
		.frame_height (frame_height),
		.res          (video.res),
		.change_count (change_count)
	);

	hblank_trimmer hblank_trimmer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.video       (video),
		.trims       (trims),
		.line_hbl    (line_hbl),
		.line_width  (line_width),
		.width_valid (width_valid)
	);

	vblank_trimmer vblank_trimmer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.video        (video),
		.trims        (trims),
		.line_hbl     (line_hbl),
		.de           (de),
		.line_idx     (line_idx),
		.frame_height (frame_height),
		.frame_done   (frame_done)
	);

	mode_monitor mode_monitor_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.res          (video.res),
		.line_width   (line_width),
		.width_valid  (width_valid),
		.line_idx     (line_idx),
		.frame_height (frame_height),
		.frame_done   (frame_done),
		.meas_width   (meas_width),
		.change_count (change_count)
	);

endmodule

// ==== rtl/mode_monitor.sv ====
// width is taken from line one only, the first frame after reset counts as a change
`timescale 1ns/1ps

module mode_monitor (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic [1:0]               res,
	input  video_timing_pkg::coord_t line_width,
	input  logic                     width_valid,
	input  video_timing_pkg::coord_t line_idx,
	input  video_timing_pkg::coord_t frame_height,
	input  logic                     frame_done,
	output video_timing_pkg::coord_t meas_width,
	output logic [6:0]               change_count
);
	import video_timing_pkg::*;

	coord_t     snap_width;   // previous frame
	coord_t     snap_height;
	logic [1:0] snap_res;
	logic       mode_changed;

	assign mode_changed = (meas_width != snap_width) |
		(frame_height != snap_height) |
		(res != snap_res);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			meas_width   <= '0;
			snap_width   <= '0;
			snap_height  <= '0;
			snap_res     <= '0;
			change_count <= '0;
		end else begin
			if (width_valid && line_idx == coord_t'(1)) meas_width <= line_width;

			if (frame_done) begin
				snap_width  <= meas_width;
				snap_height <= frame_height;
				snap_res    <= res;
				if (mode_changed) change_count <= change_count + 1'b1; // wraps at 128
			end
		end
	end

endmodule

// ==== rtl/vblank_trimmer.sv ====
// frame blank is vblank or vsync, vertical trims act at the start of each line
`timescale 1ns/1ps

module vblank_trimmer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  video_timing_pkg::video_in_t video,
	input  video_timing_pkg::trim_t   trims,
	input  logic                      line_hbl,
	output logic                      de,
	output video_timing_pkg::coord_t  line_idx,
	output video_timing_pkg::coord_t  frame_height,
	output logic                      frame_done
);
	import video_timing_pkg::*;

	coord_t first_line;   // line of vblank fall
	coord_t last_line;    // line count at vblank rise
	coord_t sync_end;
	coord_t top_line;
	coord_t bottom_line;
	logic   frame_blank;
	logic   old_blank;
	logic   old_hs_n;
	logic   old_vs_n;
	logic   old_hbl;
	logic   vb_rise;
	logic   vb_fall;
	logic   hs_fall;
	logic   line_start;
	logic   trim_vbl;
	logic   force_vbl;

	assign frame_blank = video.vblank | ~video.vs_n;
	assign vb_rise     = frame_blank & ~old_blank;
	assign vb_fall     = ~frame_blank & old_blank;
	assign hs_fall     = old_hs_n & ~video.hs_n;
	assign line_start  = (old_hbl & ~line_hbl) | (line_idx == '0);
	assign top_line    = first_line + trims.top;

	// absolute line, or an offset back from the last line
	assign bottom_line = trims.bottom.rel_line.from_end ?
		last_line - coord_t'(trims.bottom.rel_line.back_lines) :
		trims.bottom.abs_line;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			line_idx     <= '0;
			first_line   <= '0;
			last_line    <= '0;
			sync_end     <= '0;
			frame_height <= '0;
			frame_done   <= 1'b0;
			old_blank    <= 1'b1;
			old_hs_n     <= 1'b1;
			old_vs_n     <= 1'b1;
			old_hbl      <= 1'b1;
			trim_vbl     <= 1'b1;
			force_vbl    <= 1'b1;
			de           <= 1'b0;
		end else begin
			old_blank  <= frame_blank;
			old_hs_n   <= video.hs_n;
			old_vs_n   <= video.vs_n;
			old_hbl    <= line_hbl;
			frame_done <= vb_rise;

			if (hs_fall) line_idx <= line_idx + 1'b1;
			if (vb_rise) begin
				line_idx     <= '0;
				last_line    <= line_idx;
				frame_height <= line_idx - first_line;
			end
			if (vb_fall) first_line <= line_idx;
			if (~old_vs_n & video.vs_n) sync_end <= line_idx;

			if (line_start) begin
				if (line_idx == top_line)    trim_vbl <= 1'b0;
				if (line_idx == bottom_line) trim_vbl <= 1'b1;

				// one line kept dark next to sync and at frame end
				if (line_idx == last_line)         force_vbl <= 1'b1;
				if (line_idx == sync_end + 2'd2)   force_vbl <= 1'b0;
			end

			de <= ~(line_hbl | trim_vbl | force_vbl);
		end
	end

endmodule

// ==== rtl/hblank_trimmer.sv ====
// one clk_sys per pixel assumed, hblank edges must fall inside the hs_n high period
`timescale 1ns/1ps

module hblank_trimmer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  video_timing_pkg::video_in_t video,
	input  video_timing_pkg::trim_t   trims,
	output logic                      line_hbl,
	output video_timing_pkg::coord_t  line_width,
	output logic                      width_valid
);
	import video_timing_pkg::*;

	coord_t hcnt;
	coord_t act_start;   // count at hblank fall
	coord_t act_end;     // count at hblank rise
	coord_t line_len;    // count at hs_n fall
	coord_t trim_open;
	coord_t trim_close;
	logic   old_hs_n;
	logic   old_hblank;
	logic   hbl_fall;
	logic   hbl_rise;
	logic   hs_fall;
	logic   trim_hbl;
	logic   force_hbl;

	assign hbl_fall   = old_hblank & ~video.hblank;
	assign hbl_rise   = ~old_hblank & video.hblank;
	assign hs_fall    = old_hs_n & ~video.hs_n;
	assign trim_open  = act_start + trims.left - trim_bias;
	assign trim_close = act_end + trims.right - trim_bias;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcnt        <= '0;
			act_start   <= '0;
			act_end     <= '0;
			line_len    <= '0;
			line_width  <= '0;
			width_valid <= 1'b0;
			old_hs_n    <= 1'b1;
			old_hblank  <= 1'b1;
			trim_hbl    <= 1'b1;
			force_hbl   <= 1'b1;
		end else begin
			old_hs_n    <= video.hs_n;
			old_hblank  <= video.hblank;
			width_valid <= hbl_rise;

			hcnt <= video.hs_n ? hcnt + 1'b1 : '0; // held at zero during sync

			if (hbl_fall) act_start <= hcnt;
			if (hbl_rise) begin
				act_end    <= hcnt;
				line_width <= hcnt - act_start;
			end
			if (hs_fall) line_len <= hcnt;

			// right edge wins when both match
			if (hcnt == trim_open)  trim_hbl <= 1'b0;
			if (hcnt == trim_close) trim_hbl <= 1'b1;

			if (hcnt == force_margin)            force_hbl <= 1'b0;
			if (hcnt == line_len - force_margin) force_hbl <= 1'b1;
		end
	end

	assign line_hbl = trim_hbl | force_hbl | ~video.hs_n;

endmodule

// ==== rtl/border_apb_regs.sv ====
// every access is setup plus one access cycle, paddr must hold across both
`timescale 1ns/1ps

module border_apb_regs (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  border_regs_pkg::apb_req_t  apb_req,
	output border_regs_pkg::apb_rsp_t  apb_rsp,
	output video_timing_pkg::trim_t    trims,
	input  video_timing_pkg::coord_t   meas_width,
	input  video_timing_pkg::coord_t   frame_height,
	input  logic [1:0]                 res,
	input  logic [6:0]                 change_count
);
	import border_regs_pkg::*;
	import video_timing_pkg::*;

	logic              setup;
	logic              access;
	logic              mapped;
	logic              read_only;
	logic              wr_en;
	logic [data_w-1:0] rd_data;
	logic [data_w-1:0] prdata_q;
	logic              pslverr_q;

	assign setup  = apb_req.psel & ~apb_req.penable;
	assign access = apb_req.psel & apb_req.penable;

	// address decode and read mux
	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		rd_data   = '0;
		case (apb_req.paddr)
			reg_trim_left:   rd_data[coord_w-1:0] = trims.left;
			reg_trim_right:  rd_data[coord_w-1:0] = trims.right;
			reg_trim_top:    rd_data[coord_w-1:0] = trims.top;
			reg_trim_bottom: rd_data[coord_w-1:0] = trims.bottom.abs_line; // raw word
			reg_hsize: begin
				rd_data[coord_w-1:0] = meas_width;
				read_only            = 1'b1;
			end
			reg_vsize: begin
				rd_data[coord_w-1:0] = frame_height;
				read_only            = 1'b1;
			end
			reg_mode: begin
				rd_data[mode_res_lsb +: 2] = res;
				rd_data[mode_cnt_lsb +: 7] = change_count;
				read_only                  = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign wr_en = access & apb_req.pwrite & mapped & ~read_only;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			trims <= '0;
		end else if (wr_en) begin
			case (apb_req.paddr)
				reg_trim_left:   trims.left   <= apb_req.pwdata[coord_w-1:0];
				reg_trim_right:  trims.right  <= apb_req.pwdata[coord_w-1:0];
				reg_trim_top:    trims.top    <= apb_req.pwdata[coord_w-1:0];
				reg_trim_bottom: trims.bottom <= bottom_trim_u'(apb_req.pwdata[coord_w-1:0]);
				default:         trims        <= trims;
			endcase
		end
	end

	// response is prepared in the setup cycle and shown in the access cycle
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pslverr_q <= 1'b0;
		end else begin
			pslverr_q <= setup & (~mapped | (apb_req.pwrite & read_only));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (setup) begin
			prdata_q <= rd_data;
		end
	end

	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pready  = 1'b1; // never waits
	assign apb_rsp.pslverr = pslverr_q;

endmodule

// ==== rtl/border_regs_pkg.sv ====
// APB3 subset with byte addresses, 32 bit data and no wait states
package border_regs_pkg;

	localparam int addr_w = 8;
	localparam int data_w = 32;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [addr_w-1:0] paddr;
		logic [data_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [data_w-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// trims, read/write
	localparam logic [addr_w-1:0] reg_trim_left   = 8'h00;
	localparam logic [addr_w-1:0] reg_trim_right  = 8'h04;
	localparam logic [addr_w-1:0] reg_trim_top    = 8'h08;
	localparam logic [addr_w-1:0] reg_trim_bottom = 8'h0C;

	// measurements, read only
	localparam logic [addr_w-1:0] reg_hsize       = 8'h10;
	localparam logic [addr_w-1:0] reg_vsize       = 8'h14;
	localparam logic [addr_w-1:0] reg_mode        = 8'h18;

	// field positions inside reg_mode
	localparam int mode_res_lsb = 0;
	localparam int mode_cnt_lsb = 8;

endpackage

// ==== rtl/video_timing_pkg.sv ====
// positions are 12 bit and wrap at 4096, one field per frame, no interlace support
package video_timing_pkg;

	localparam int coord_w = 12;

	typedef logic [coord_w-1:0] coord_t;

	// raw timing of one clk_sys cycle
	typedef struct packed {
		logic       hs_n;   // active low
		logic       vs_n;   // active low
		logic       hblank;
		logic       vblank;
		logic [1:0] res;    // lores / hires / shres code
	} video_in_t;

	// bottom trim counted back from the last line of the frame
	typedef struct packed {
		logic               from_end;
		logic [coord_w-2:0] back_lines;
	} rel_bottom_t;

	// top bit selects which view is in force
	typedef union packed {
		coord_t      abs_line;
		rel_bottom_t rel_line;
	} bottom_trim_u;

	typedef struct packed {
		coord_t       left;
		coord_t       right;
		coord_t       top;
		bottom_trim_u bottom;
	} trim_t;

	localparam coord_t force_margin = coord_t'(8);  // pixels at each line end
	localparam coord_t trim_bias    = coord_t'(2);  // edge detect plus compare delay

endpackage
